// File: src.f
bcdCalcPkg.sv
bcdSequencer.sv
operandRegs.sv
bcdAdder.sv
segDisplay.sv
bcdCalcTop.sv
bcdCalcTb.sv

// File: bcdCalcTb.sv
`timescale 1ns/1ns

module bcdCalcTb
    import bcdCalcPkg::*;
();

    logic      clock;
    logic      rstN;
    bcdPairT   switches;
    buttonsT   buttons;
    segPairT   segments;
    logic      error;
    logic      ready;

    int          errorCount;
    int          cycleCount;
    logic [31:0] rngState;
    // Operand values as plain decimal numbers
    int          modelA;
    int          modelB;

    bcdCalcTop DUT
    (
        .clock    (clock),
        .rstN     (rstN),
        .switches (switches),
        .buttons  (buttons),
        .segments (segments),
        .error    (error),
        .ready    (ready)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Active-high gfedcba patterns
    function automatic logic [6:0] segOf(input int d);
        case (d)
            0:       return 7'h3F;
            1:       return 7'h06;
            2:       return 7'h5B;
            3:       return 7'h4F;
            4:       return 7'h66;
            5:       return 7'h6D;
            6:       return 7'h7D;
            7:       return 7'h07;
            8:       return 7'h7F;
            9:       return 7'h6F;
            default: return 7'h00;
        endcase
    endfunction

    // Decimal 0 to 99 into two nibbles
    function automatic logic [7:0] toBcd(input int v);
        logic [7:0] w;
        w[7:4] = v / 10;
        w[3:0] = v % 10;
        return w;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic buttonsT buttonWord(input logic la, input logic lb,
                                           input logic sl, input logic sh);
        buttonsT b;
        b.loadAReq    = la;
        b.loadBReq    = lb;
        b.showLowReq  = sl;
        b.showHighReq = sh;
        return b;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and handshake helpers
    ////////////////////////////////////////////////////////////

    task automatic checkSegments(input logic [6:0] expLeft, input logic [6:0] expRight);
        if (segments.left !== expLeft)
        begin
            $display("FAILED segments.left expected %h actual %h", expLeft, segments.left);
            errorCount++;
        end
        if (segments.right !== expRight)
        begin
            $display("FAILED segments.right expected %h actual %h", expRight, segments.right);
            errorCount++;
        end
    endtask

    task automatic checkError(input logic expError);
        if (error !== expError)
        begin
            $display("FAILED error expected %h actual %h", expError, error);
            errorCount++;
        end
    endtask

    // Ready must drop and come back; busyPress is held while it is low
    task automatic waitReady(input buttonsT busyPress);
        int   waitCycles;
        logic seenLow;
        waitCycles = 0;
        seenLow    = 1'b0;
        while (!(seenLow && ready))
        begin
            @(posedge clock);
            #10;
            waitCycles++;
            if (!ready)
                seenLow = 1'b1;
            buttons = ready ? buttonsT'('0) : busyPress;
            if (waitCycles > 20)
            begin
                $display("DUT hang: ready did not return within 20 cycles");
                errorCount++;
                buttons = '0;
                return;
            end
        end
    endtask

    // Called 10 ns after an edge with ready high
    task automatic pressButton(input buttonsT b, input buttonsT busyPress);
        buttons = b;
        waitReady(busyPress);
    endtask

    task automatic loadOperand(input logic toB, input int value);
        switches.raw = toBcd(value);
        pressButton(toB ? buttonWord(0, 1, 0, 0) : buttonWord(1, 0, 0, 0), '0);
        if (toB)
            modelB = value;
        else
            modelA = value;
        // Load is followed by display of the same operand
        checkSegments(segOf(value / 10), segOf(value % 10));
        checkError(1'b0);
    endtask

    task automatic showLow();
        int sum;
        pressButton(buttonWord(0, 0, 1, 0), '0);
        sum = modelA + modelB;
        checkSegments(segOf((sum / 10) % 10), segOf(sum % 10));
    endtask

    task automatic showHigh();
        int sum;
        pressButton(buttonWord(0, 0, 0, 1), '0);
        sum = modelA + modelB;
        // Blank left, hundreds right
        checkSegments(7'h00, segOf(sum / 100));
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic resetDut();
        int waitCycles;
        rstN = 1'b0;
        repeat (10) @(posedge clock);
        #10;
        checkSegments(7'h00, 7'h00);
        checkError(1'b0);
        if (ready !== 1'b0)
        begin
            $display("FAILED ready expected %h actual %h", 1'b0, ready);
            errorCount++;
        end
        rstN = 1'b1;
        // Init command runs before buttons are taken
        waitCycles = 0;
        while (ready !== 1'b1 && waitCycles <= 20)
        begin
            @(posedge clock);
            #10;
            waitCycles++;
        end
        if (ready !== 1'b1)
        begin
            $display("DUT hang: ready did not rise after reset");
            errorCount++;
        end
    endtask

    task automatic checkAfterReset();
        checkSegments(7'h00, 7'h00);
        checkError(1'b0);
        modelA = 0;
        modelB = 0;
        showLow();
        showHigh();
    endtask

    task automatic runKnownSums();
        // 47 + 85 = 132
        loadOperand(1'b0, 47);
        loadOperand(1'b1, 85);
        showLow();
        showHigh();
        // Largest sum, 198
        loadOperand(1'b0, 99);
        loadOperand(1'b1, 99);
        showLow();
        showHigh();
        loadOperand(1'b0, 0);
        loadOperand(1'b1, 0);
        showLow();
        showHigh();
    endtask

    task automatic rejectBadSwitches();
        loadOperand(1'b0, 36);
        loadOperand(1'b1, 58);
        // Ones digit C
        switches.raw = 8'h3C;
        pressButton(buttonWord(1, 0, 0, 0), '0);
        checkError(1'b1);
        checkSegments(segOf(modelA / 10), segOf(modelA % 10));
        showLow();
        checkError(1'b1);
        // Valid word clears the sticky flag
        loadOperand(1'b0, 71);
        // Tens digit A on operand B
        switches.raw = 8'hA5;
        pressButton(buttonWord(0, 1, 0, 0), '0);
        checkError(1'b1);
        checkSegments(segOf(modelB / 10), segOf(modelB % 10));
        showHigh();
        showLow();
    endtask

    task automatic ignoreBusyButtons();
        loadOperand(1'b1, 55);
        switches.raw = toBcd(12);
        // Extra presses during the load must not be queued
        pressButton(buttonWord(1, 0, 0, 0), buttonWord(0, 1, 0, 1));
        modelA = 12;
        checkSegments(segOf(1), segOf(2));
        showLow();
        // Two at once, show-low beats load A
        switches.raw = toBcd(77);
        pressButton(buttonWord(1, 0, 1, 0), '0);
        checkSegments(segOf(6), segOf(7));
        // Show-high beats load B
        pressButton(buttonWord(0, 1, 0, 1), '0);
        checkSegments(7'h00, segOf(0));
        // All four, show-high wins
        pressButton(buttonWord(1, 1, 1, 1), '0);
        checkSegments(7'h00, segOf(0));
        // Operands untouched by the losers
        showLow();
        checkError(1'b0);
    endtask

    task automatic randomPairs();
        int a;
        int b;
        for (int i = 0; i < 50; i++)
        begin
            rngState = xorshift(rngState);
            a = rngState % 100;
            rngState = xorshift(rngState);
            b = rngState % 100;
            loadOperand(1'b0, a);
            loadOperand(1'b1, b);
            showLow();
            showHigh();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Run and summary
    ////////////////////////////////////////////////////////////

    initial
    begin
        errorCount = 0;
        rngState   = 32'he893;
        rstN       = 1'b0;
        buttons    = '0;
        switches   = '0;
        modelA     = 0;
        modelB     = 0;
        resetDut();
        checkAfterReset();
        runKnownSums();
        rejectBadSwitches();
        ignoreBusyButtons();
        randomPairs();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // About 250 operations of up to 6 cycles, plus reset and margin
    initial
    begin
        cycleCount = 0;
        while (cycleCount < 3000)
        begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout: run did not finish within 3000 cycles");
        $display("Errors: %0d", errorCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: bcdCalcTop.sv
`timescale 1ns/1ns

module bcdCalcTop
    import bcdCalcPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    input  bcdPairT switches,
    input  buttonsT buttons,
    output segPairT segments,
    output logic    error,
    output logic    ready
);

    ctrlCmdT   cmd;
    // Each block answers its own commands only
    ctrlAckT   regAcks;
    ctrlAckT   dispAcks;
    ctrlAckT   acks;
    bcdPairT   operandA;
    bcdPairT   operandB;
    sumDigitsT sum;

    // Disjoint bits, OR merges them
    assign acks = regAcks | dispAcks;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    bcdSequencer uSequencer
    (
        .clock   (clock),
        .rstN    (rstN),
        .buttons (buttons),
        .acks    (acks),
        .cmd     (cmd),
        .ready   (ready)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // Operand storage beside the adder it feeds
    operandRegs uOperandRegs
    (
        .clock    (clock),
        .rstN     (rstN),
        .cmd      (cmd),
        .switches (switches),
        .operandA (operandA),
        .operandB (operandB),
        .acks     (regAcks),
        .error    (error)
    );

    bcdAdder uAdder
    (
        .operandA (operandA),
        .operandB (operandB),
        .sum      (sum)
    );

    segDisplay uDisplay
    (
        .clock    (clock),
        .rstN     (rstN),
        .cmd      (cmd),
        .operandA (operandA),
        .operandB (operandB),
        .sum      (sum),
        .acks     (dispAcks),
        .segments (segments)
    );

endmodule

// File: segDisplay.sv
`timescale 1ns/1ns

module segDisplay
    import bcdCalcPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  ctrlCmdT   cmd,
    input  bcdPairT   operandA,
    input  bcdPairT   operandB,
    input  sumDigitsT sum,
    output ctrlAckT   acks,
    output segPairT   segments
);

    ctrlCmdT  prevCmd;
    logic     showAStart;
    logic     showBStart;
    logic     showLsStart;
    logic     showMsStart;

    // Latched digits and their blank flags
    bcdDigitT leftDigit;
    bcdDigitT rightDigit;
    logic     leftBlank;
    logic     rightBlank;

    // Digit to pattern, dark when blank
    function automatic logic [6:0] decode(input bcdDigitT d, input logic blank);
        if (blank || d > BCD_MAX)
            return SEG_BLANK;
        return SEG_TABLE[d];
    endfunction

    // First cycle of each display command
    assign showAStart  = cmd.displayA && !prevCmd.displayA;
    assign showBStart  = cmd.displayB && !prevCmd.displayB;
    assign showLsStart = cmd.displayLs && !prevCmd.displayLs;
    assign showMsStart = cmd.displayMs && !prevCmd.displayMs;

    ////////////////////////////////////////////////////////////
    // Control and acknowledge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            prevCmd    <= '0;
            acks       <= '0;
            leftBlank  <= 1'b1;
            rightBlank <= 1'b1;
        end
        else
        begin
            prevCmd <= cmd;

            // init and load answers come from operandRegs
            acks              <= '0;
            acks.displayAAck  <= showAStart;
            acks.displayBAck  <= showBStart;
            acks.displayLsAck <= showLsStart;
            acks.displayMsAck <= showMsStart;

            // init darkens both digits, no answer
            if (cmd.init)
            begin
                leftBlank  <= 1'b1;
                rightBlank <= 1'b1;
            end
            else if (showAStart || showBStart || showLsStart)
            begin
                leftBlank  <= 1'b0;
                rightBlank <= 1'b0;
            end
            else if (showMsStart)
            begin
                // Hundreds on the right only
                leftBlank  <= 1'b1;
                rightBlank <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Digit latch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (showAStart)
        begin
            leftDigit  <= operandA.digits.msDigit;
            rightDigit <= operandA.digits.lsDigit;
        end
        else if (showBStart)
        begin
            leftDigit  <= operandB.digits.msDigit;
            rightDigit <= operandB.digits.lsDigit;
        end
        else if (showLsStart)
        begin
            leftDigit  <= sum.tens;
            rightDigit <= sum.ones;
        end
        else if (showMsStart)
            rightDigit <= sum.hundreds;
    end

    // Segment drive
    always_comb
    begin
        segments.left  = decode(leftDigit, leftBlank);
        segments.right = decode(rightDigit, rightBlank);
    end

endmodule

// File: bcdAdder.sv
`timescale 1ns/1ns

module bcdAdder
    import bcdCalcPkg::*;
(
    input  bcdPairT   operandA,
    input  bcdPairT   operandB,
    output sumDigitsT sum
);

    // Carry out of each digit stage
    logic     onesCarry;
    logic     tensCarry;
    bcdDigitT onesDigit;
    bcdDigitT tensDigit;

    ////////////////////////////////////////////////////////////
    // One decimal digit stage
    ////////////////////////////////////////////////////////////

    // Returns {carry, digit}
    function automatic logic [4:0] digitAdd(
        input bcdDigitT a,
        input bcdDigitT b,
        input logic     carryIn
    );
        logic [4:0] binSum;
        logic [4:0] adjSum;
        binSum = {1'b0, a} + {1'b0, b} + {4'b0000, carryIn};
        // Past nine, skip the six unused codes
        adjSum = binSum + 5'd6;
        if (binSum > 5'd9)
            return {1'b1, adjSum[3:0]};
        else
            return {1'b0, binSum[3:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Ripple across the two digits
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Ones first, no carry in
        {onesCarry, onesDigit} = digitAdd(operandA.digits.lsDigit,
                                          operandB.digits.lsDigit, 1'b0);
        // Tens take the ones carry
        {tensCarry, tensDigit} = digitAdd(operandA.digits.msDigit,
                                          operandB.digits.msDigit, onesCarry);
    end

    // Final carry is the whole hundreds digit
    assign sum.hundreds = {3'b000, tensCarry};
    assign sum.tens     = tensDigit;
    assign sum.ones     = onesDigit;

endmodule

// File: operandRegs.sv
`timescale 1ns/1ns

module operandRegs
    import bcdCalcPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    input  ctrlCmdT cmd,
    input  bcdPairT switches,
    output bcdPairT operandA,
    output bcdPairT operandB,
    output ctrlAckT acks,
    output logic    error
);

    // Command word one edge back, for start detection
    ctrlCmdT prevCmd;
    logic    initStart;
    logic    loadAStart;
    logic    loadBStart;
    logic    switchesValid;

    // First cycle of each owned command
    assign initStart  = cmd.init && !prevCmd.init;
    assign loadAStart = cmd.loadA && !prevCmd.loadA;
    assign loadBStart = cmd.loadB && !prevCmd.loadB;

    // Both switch digits must be decimal
    assign switchesValid = (switches.digits.msDigit <= BCD_MAX)
                        && (switches.digits.lsDigit <= BCD_MAX);

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            prevCmd  <= '0;
            acks     <= '0;
            error    <= 1'b0;
            operandA <= '0;
            operandB <= '0;
        end
        else
        begin
            prevCmd <= cmd;

            // Display bits belong to segDisplay
            acks              <= '0;
            acks.initAck      <= initStart;
            acks.loadAAck     <= loadAStart;
            acks.loadBAck     <= loadBStart;

            if (initStart)
            begin
                operandA <= '0;
                operandB <= '0;
                error    <= 1'b0;
            end
            else if (loadAStart)
            begin
                // Bad word keeps the old operand
                if (switchesValid)
                    operandA.raw <= switches.raw;
                error <= !switchesValid;
            end
            else if (loadBStart)
            begin
                if (switchesValid)
                    operandB.raw <= switches.raw;
                error <= !switchesValid;
            end
        end
    end

    // Adder and display see decimal digits only
    digitsInRange: assert property (@(posedge clock) disable iff (!rstN)
        (operandA.digits.msDigit <= BCD_MAX) && (operandA.digits.lsDigit <= BCD_MAX)
        && (operandB.digits.msDigit <= BCD_MAX) && (operandB.digits.lsDigit <= BCD_MAX))
        else $error("stored operand out of range: A=%h B=%h", operandA, operandB);

endmodule

// File: bcdSequencer.sv
`timescale 1ns/1ns

module bcdSequencer
    import bcdCalcPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    input  buttonsT buttons,
    input  ctrlAckT acks,
    output ctrlCmdT cmd,
    output logic    ready
);

    ////////////////////////////////////////////////////////////
    // State and request storage
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        INIT,
        WAIT,
        LOAD_A,
        DISPLAY_A,
        LOAD_B,
        DISPLAY_B,
        SHOW_LOW,
        SHOW_HIGH
    } stateT;

    stateT   state;
    stateT   nextState;

    // Button word taken in WAIT, acted on one edge later
    buttonsT pendingReq;

    // Command level owned by each state
    function automatic ctrlCmdT cmdFor(input stateT s);
        ctrlCmdT c;
        c = '0;
        case (s)
            INIT:      c.init      = 1'b1;
            LOAD_A:    c.loadA     = 1'b1;
            LOAD_B:    c.loadB     = 1'b1;
            DISPLAY_A: c.displayA  = 1'b1;
            DISPLAY_B: c.displayB  = 1'b1;
            SHOW_LOW:  c.displayLs = 1'b1;
            SHOW_HIGH: c.displayMs = 1'b1;
            default:   c = '0;
        endcase
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        nextState = state;
        case (state)
            INIT:
            begin
                // Operands cleared, start taking buttons
                if (acks.initAck)
                    nextState = WAIT;
            end
            WAIT:
            begin
                // Highest priority first
                if (pendingReq.showHighReq)
                    nextState = SHOW_HIGH;
                else if (pendingReq.showLowReq)
                    nextState = SHOW_LOW;
                else if (pendingReq.loadBReq)
                    nextState = LOAD_B;
                else if (pendingReq.loadAReq)
                    nextState = LOAD_A;
            end
            LOAD_A:
            begin
                // Loaded operand is shown right away
                if (acks.loadAAck)
                    nextState = DISPLAY_A;
            end
            LOAD_B:
            begin
                if (acks.loadBAck)
                    nextState = DISPLAY_B;
            end
            DISPLAY_A:
            begin
                if (acks.displayAAck)
                    nextState = WAIT;
            end
            DISPLAY_B:
            begin
                if (acks.displayBAck)
                    nextState = WAIT;
            end
            SHOW_LOW:
            begin
                if (acks.displayLsAck)
                    nextState = WAIT;
            end
            SHOW_HIGH:
            begin
                if (acks.displayMsAck)
                    nextState = WAIT;
            end
            default:
            begin
                nextState = INIT;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            state      <= INIT;
            cmd        <= '0;
            ready      <= 1'b0;
            pendingReq <= '0;
        end
        else
        begin
            state <= nextState;
            // Command follows the state being entered
            cmd   <= cmdFor(nextState);
            ready <= (nextState == WAIT);
            // Only an idle WAIT samples buttons, nothing is queued
            if (state == WAIT && pendingReq == '0)
                pendingReq <= buttons;
            else
                pendingReq <= '0;
        end
    end

    // Never two commands toward the datapath at once
    cmdOneHot: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0(cmd))
        else $error("command word not one-hot: %h", cmd);

    // Datapath blocks answer only a live command
    ackMatchesCmd: assert property (@(posedge clock) disable iff (!rstN)
        (acks & ~cmd) == '0)
        else $error("acknowledge %h without command %h", acks, cmd);

endmodule

// File: bcdCalcPkg.sv
package bcdCalcPkg;

    ////////////////////////////////////////////////////////////
    // Digits and operands
    ////////////////////////////////////////////////////////////

    // One decimal digit, valid range 0 to 9
    typedef logic [3:0] bcdDigitT;

    // Largest legal value of a digit
    localparam bcdDigitT BCD_MAX = 4'd9;

    // Tens and ones of a two-digit operand
    typedef struct packed
    {
        bcdDigitT msDigit;
        bcdDigitT lsDigit;
    } bcdDigitsT;

    // Switch word and stored operand
    // raw for capture, digits for checking and adding
    typedef union packed
    {
        logic [7:0] raw;
        bcdDigitsT  digits;
    } bcdPairT;

    // Adder result, 000 to 198
    typedef struct packed
    {
        bcdDigitT hundreds;
        bcdDigitT tens;
        bcdDigitT ones;
    } sumDigitsT;

    ////////////////////////////////////////////////////////////
    // Command and acknowledge words
    ////////////////////////////////////////////////////////////

    // Levels from the sequencer, at most one high
    typedef struct packed
    {
        logic init;
        logic loadA;
        logic loadB;
        logic displayA;
        logic displayB;
        logic displayLs;
        logic displayMs;
    } ctrlCmdT;

    // One-cycle answers, same bit order as the commands
    typedef struct packed
    {
        logic initAck;
        logic loadAAck;
        logic loadBAck;
        logic displayAAck;
        logic displayBAck;
        logic displayLsAck;
        logic displayMsAck;
    } ctrlAckT;

    // Operator buttons
    typedef struct packed
    {
        logic loadAReq;
        logic loadBReq;
        logic showLowReq;
        logic showHighReq;
    } buttonsT;

    ////////////////////////////////////////////////////////////
    // Seven-segment output
    ////////////////////////////////////////////////////////////

    // Bit order gfedcba, lit segment is 1
    typedef struct packed
    {
        logic [6:0] left;
        logic [6:0] right;
    } segPairT;

    // Patterns for 0 to 9
    localparam logic [6:0] SEG_TABLE [0:9] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
        7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };

    // All segments dark
    localparam logic [6:0] SEG_BLANK = 7'h00;

endpackage
